/* Makefile */
SRCS := $(shell cat flist.f)

.PHONY: run clean

obj_dir/VsingleCpuTb: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module singleCpuTb -f flist.f

run: obj_dir/VsingleCpuTb
	./obj_dir/VsingleCpuTb 2>&1 | tee sim.log
	@! grep -q "RESULT: FAIL" sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu.sv */
`timescale 1ns/1ps

module alu import rvCorePkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpT       op,
    output logic [31:0] result,
    output logic        zero
);

    logic lessSigned;

    assign lessSigned = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lessSigned};
            ALU_PASS: result = b;
            default:  result = '0;
        endcase
    end

    // Equality test for BEQ
    assign zero = (result == '0);

endmodule

/* dataMemory.sv */
`timescale 1ns/1ps

module dataMemory import rvCorePkg::*; (
    input  logic            CLK,
    input  logic            run,
    input  logic [31:0]     addr,
    input  logic            writeEnable,
    input  logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData
);

    logic [XLEN-1:0]    mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordIndex;

    // Cleared at power-up
    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIndex = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (run && writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end

    assign readData = mem[wordIndex];             // Asynchronous read

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder import rvCorePkg::*; (
    input  logic [31:0] instr,
    output ctrlT        ctrl,
    output logic [31:0] imm
);

    opcodeT      opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];                  // SUB versus ADD

    // Sign-extended immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = ALU_ADD;
        ctrl.rs1       = instr[19:15];
        ctrl.rs2       = instr[24:20];
        ctrl.rd        = instr[11:7];
        imm            = '0;

        case (opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                case ({funct7b5, funct3})
                    4'b0_000: ctrl.aluOp = ALU_ADD;
                    4'b1_000: ctrl.aluOp = ALU_SUB;
                    4'b0_111: ctrl.aluOp = ALU_AND;
                    4'b0_110: ctrl.aluOp = ALU_OR;
                    4'b0_010: ctrl.aluOp = ALU_SLT;
                    default:  ctrl.regWrite = 1'b0;   // Unsupported R-type
                endcase
            end
            OPIMM: begin
                if (funct3 == 3'b000) begin           // ADDI only
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    imm            = immI;
                end
            end
            LOAD: begin
                if (funct3 == 3'b010) begin           // LW
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memToReg  = 1'b1;
                    imm            = immI;
                end
            end
            STORE: begin
                if (funct3 == 3'b010) begin           // SW
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    imm            = immS;
                end
            end
            BRANCH: begin
                if (funct3 == 3'b000) begin           // BEQ compares by subtraction
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = ALU_SUB;
                    imm         = immB;
                end
            end
            default: ;
        endcase
    end

endmodule

/* flist.f */
rvCorePkg.sv
instructionMemory.sv
registerFile.sv
decoder.sv
alu.sv
dataMemory.sv
singleCpu.sv
singleCpu_assert.sv
singleCpuTb.sv

/* instructionMemory.sv */
`timescale 1ns/1ps

module instructionMemory import rvCorePkg::*; (
    input  logic            CLK,
    input  progWriteT       progWrite,
    input  logic [31:0]     pc,
    output logic [31:0]     instr
);

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Empty slots trap a runaway PC in place
    initial begin
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            mem[i] = SELF_BRANCH;
        end
    end

    always_ff @(posedge CLK) begin
        if (progWrite.valid) begin
            mem[progWrite.addr] <= progWrite.data;
        end
    end

    // Byte address to word index
    assign instr = mem[pc[IMEM_AW+1:2]];

endmodule

/* program_golden.txt */
# P <word index> <instruction word>, both hex
# E <rd> <written value>, both hex, in retire order
P 00 00500093
P 01 ffd00113
P 02 00708013
P 03 000081b3
P 04 00208233
P 05 402082b3
P 06 0020f333
P 07 0020e3b3
P 08 00112433
P 09 0020a4b3
P 0a 00502423
P 0b 00202623
P 0c 00802503
P 0d 00c02583
P 0e 01002603
P 0f 00308663
P 10 00100693
P 11 00200693
P 12 00208463
P 13 00300713
P 14 00000793
P 15 00300813
P 16 00178793
P 17 fff80813
P 18 00080463
P 19 fe000ae3
P 1a 00078893
P 1b 00000063
E 01 00000005
E 02 fffffffd
E 03 00000005
E 04 00000002
E 05 00000008
E 06 00000005
E 07 fffffffd
E 08 00000001
E 09 00000000
E 0a 00000008
E 0b fffffffd
E 0c 00000000
E 0e 00000003
E 0f 00000000
E 10 00000003
E 0f 00000001
E 10 00000002
E 0f 00000002
E 10 00000001
E 0f 00000003
E 10 00000000
E 11 00000003

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile import rvCorePkg::*; (
    input  logic            CLK,
    input  logic            reset,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            writeEnable,
    input  logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData1,
    output logic [XLEN-1:0] readData2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != 5'd0) begin
            regs[rd] <= writeData;                // x0 stays untouched
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign readData1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rvCorePkg.sv */
package rvCorePkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 256;              // Words
    localparam int DMEM_DEPTH = 256;              // Words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // BEQ x0, x0, 0 parks the PC on itself
    localparam logic [XLEN-1:0] SELF_BRANCH = 32'h0000_0063;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,                      // ADD SUB AND OR SLT
        OPIMM  = 7'b0010011,                      // ADDI
        LOAD   = 7'b0000011,                      // LW
        STORE  = 7'b0100011,                      // SW
        BRANCH = 7'b1100011                       // BEQ
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_PASS = 4'd5                           // Forward operand b
    } aluOpT;

    // Decoded control word
    typedef struct packed {
        logic       regWrite;
        logic       aluSrcImm;                    // Second ALU operand from immediate
        logic       memWrite;
        logic       memToReg;                     // Write back load data
        logic       branch;
        aluOpT      aluOp;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrlT;

    // Program load port
    typedef struct packed {
        logic               valid;
        logic [IMEM_AW-1:0] addr;                 // Word index
        logic [XLEN-1:0]    data;
    } progWriteT;

    // One entry per register write
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retireT;

endpackage

/* singleCpu.sv */
`timescale 1ns/1ps

module singleCpu import rvCorePkg::*; (
    input  logic      CLK,
    input  logic      reset,
    input  logic      run,
    input  progWriteT progWrite,
    output retireT    retire
);

    logic [31:0]     pc;
    logic [31:0]     pcPlus4;
    logic [31:0]     branchTarget;
    logic [31:0]     pcNext;
    logic [31:0]     instr;
    logic [31:0]     imm;
    ctrlT            ctrl;
    logic [XLEN-1:0] readData1;
    logic [XLEN-1:0] readData2;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            aluZero;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] writeBack;
    logic            regWriteEn;

    // Program counter
    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pcNext;
        end
    end

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm;               // B immediate already carries bit 0
    assign pcNext       = (ctrl.branch && aluZero) ? branchTarget : pcPlus4;

    instructionMemory instructionMemory_i (
        .CLK       (CLK),
        .progWrite (progWrite),
        .pc        (pc),
        .instr     (instr)
    );

    decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    // No register writes while halted
    assign regWriteEn = run && ctrl.regWrite;

    registerFile registerFile_i (
        .CLK         (CLK),
        .reset       (reset),
        .rs1         (ctrl.rs1),
        .rs2         (ctrl.rs2),
        .rd          (ctrl.rd),
        .writeEnable (regWriteEn),
        .writeData   (writeBack),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    assign aluB = ctrl.aluSrcImm ? imm : readData2;

    alu alu_i (
        .a      (readData1),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMemory dataMemory_i (
        .CLK         (CLK),
        .run         (run),
        .addr        (aluResult),
        .writeEnable (ctrl.memWrite),
        .writeData   (readData2),
        .readData    (loadData)
    );

    assign writeBack = ctrl.memToReg ? loadData : aluResult;

    // Report the write that lands on the next edge
    assign retire.valid = regWriteEn && !reset && (ctrl.rd != 5'd0);
    assign retire.rd    = ctrl.rd;
    assign retire.data  = writeBack;

endmodule

/* singleCpuTb.sv */
`timescale 1ns/1ps

module singleCpuTb import rvCorePkg::*; ();

    localparam int TAIL_CYCLES = 20;              // Quiet window after the last write

    logic      CLK;
    logic      reset;
    logic      run;
    progWriteT progWrite;
    retireT    retire;

    logic [IMEM_AW-1:0] progAddr [$];
    logic [XLEN-1:0]    progData [$];
    retireT             expQueue [$];             // Register writes still to come
    int                 cycleLimit;
    int                 cycleCount  = 0;

    singleCpu singleCpu_i (
        .CLK       (CLK),
        .reset     (reset),
        .run       (run),
        .progWrite (progWrite),
        .retire    (retire)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic compareRetire(input retireT expected, input retireT actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: expected x%0d = %h, got x%0d = %h", $time,
                     expected.rd, expected.data, actual.rd, actual.data);
            stopWithFailure("Register write differs from the golden file");
        end
    endtask

    // Program words first, then the expected writes in retire order
    task automatic loadGolden();
        int          fd;
        int          code;
        string       tag;
        string       rest;
        logic [31:0] first;
        logic [31:0] second;
        retireT      entry;
        fd = $fopen("program_golden.txt", "r");
        if (fd == 0) begin
            stopWithFailure("Could not open program_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    break;                        // End of file
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "P") begin
                    code = $fscanf(fd, "%h %h", first, second);
                    progAddr.push_back(first[IMEM_AW-1:0]);
                    progData.push_back(second);
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h", first, second);
                    entry.valid = 1'b1;
                    entry.rd    = first[4:0];
                    entry.data  = second;
                    expQueue.push_back(entry);
                end else begin
                    stopWithFailure($sformatf("Unknown record %s in the golden file", tag));
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog
    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("Timeout after %0d cycles, %0d writes never retired",
                                      cycleCount, expQueue.size()));
        end
    end

    // Retire is combinational, so look at it mid-cycle
    always @(negedge CLK) begin
        if (retire.valid === 1'b1) begin
            if (expQueue.size() == 0) begin
                stopWithFailure($sformatf("Unexpected write to x%0d with data %h at %0t",
                                          retire.rd, retire.data, $time));
            end else begin
                compareRetire(expQueue.pop_front(), retire);
            end
        end
    end

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        progWrite = '0;
        loadGolden();
        cycleLimit = 8 * progData.size() + 100;
        repeat (5) @(posedge CLK);
        #1;
        reset = 1'b0;

        // Core stays halted while the program goes in
        for (int i = 0; i < progData.size(); i++) begin
            progWrite.valid = 1'b1;
            progWrite.addr  = progAddr[i];
            progWrite.data  = progData[i];
            @(posedge CLK);
            #1;
        end
        progWrite = '0;
        run       = 1'b1;

        while (expQueue.size() != 0) begin
            @(posedge CLK);
        end
        repeat (TAIL_CYCLES) @(posedge CLK);   // Self-branch must stay silent

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* singleCpu_assert.sv */
`timescale 1ns/1ps

module singleCpu_assert import rvCorePkg::*; (
    input logic        CLK,
    input logic        reset,
    input logic        run,
    input retireT      retire,
    input logic [31:0] pc
);

    // Writes to x0 never show up on the retire port
    retireNotZero: assert property (@(posedge CLK) disable iff (reset)
        retire.valid |-> (retire.rd != 5'd0))
        else $error("Retire reported a write to x0");

    // Halted or in reset means nothing retires
    retireQuiet: assert property (@(posedge CLK) (!run || reset) |-> !retire.valid)
        else $error("Retire valid while the core is halted or in reset");

    pcAligned: assert property (@(posedge CLK) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("PC lost word alignment: %h", pc);

endmodule

bind singleCpu singleCpu_assert singleCpu_assert_i (
    .CLK    (CLK),
    .reset  (reset),
    .run    (run),
    .retire (retire),
    .pc     (pc)
);
